/* Makefile */
# Verilator flow for the EEPROM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
ARGS      ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST) $(ARGS)

# the binary exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FLIST) -Mdir $(OBJ_DIR) $(ARGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
eeprom_pkg.sv
eeprom_cfg_regs.sv
i2c_bit_engine.sv
eeprom_byte_sequencer.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

/* eeprom_byte_sequencer.sv */
`timescale 1ns/10ps

module eeprom_byte_sequencer
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       req_wr,
    input  logic                       req_rd,
    input  eeprom_pkg::eeprom_req_t    req,
    input  logic [3:0]                 dev_code,
    output logic                       busy,
    output logic                       done,
    output eeprom_pkg::eeprom_rsp_t    rsp,
    output logic                       bit_go,
    output eeprom_pkg::bit_cmd_t       bit_cmd,
    input  logic                       bit_done,
    input  logic                       bit_rx
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_CTRL_WR, ST_ADDR, ST_DATA_WR,
        ST_RESTART, ST_CTRL_RD, ST_DATA_RD, ST_STOP, ST_DONE
    } state_e;

    state_e                          state;
    logic [3:0]                      bit_cnt;   // 0..7 data, 8 ack
    logic [7:0]                      shreg;
    logic                            rd_q;
    logic                            nack_q;
    logic [eeprom_pkg::ADDR_W-1:0]   addr_q;
    logic [7:0]                      wdata_q;
    eeprom_pkg::ctrl_byte_u          ctrl;

    always_ff @(posedge CLK)
    begin
        bit_go <= 1'b0;
        done   <= 1'b0;
        if (RESET)
        begin
            state   <= ST_IDLE;
            busy    <= 1'b0;
            bit_cnt <= '0;
            rd_q    <= 1'b0;
            nack_q  <= 1'b0;
            rsp     <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (req_wr || req_rd)
                    begin
                        rd_q                <= ~req_wr;
                        addr_q              <= req.addr;
                        wdata_q             <= req.wdata;
                        ctrl.fields.dev_code <= dev_code;
                        ctrl.fields.block   <= req.addr[eeprom_pkg::ADDR_W-1:8];
                        ctrl.fields.rw      <= 1'b0;
                        nack_q              <= 1'b0;
                        busy                <= 1'b1;
                        bit_go              <= 1'b1;
                        bit_cmd             <= '{op: eeprom_pkg::BIT_START, wbit: 1'b1};
                        state               <= ST_START;
                    end
                ST_START, ST_RESTART:
                    if (bit_done)
                    begin
                        shreg   <= ctrl.raw;
                        bit_cnt <= '0;
                        bit_go  <= 1'b1;
                        bit_cmd <= '{op: eeprom_pkg::BIT_WRITE, wbit: ctrl.raw[7]};
                        state   <= (state == ST_START) ? ST_CTRL_WR : ST_CTRL_RD;
                    end
                ST_CTRL_WR, ST_ADDR, ST_DATA_WR, ST_CTRL_RD:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        bit_go  <= 1'b1;
                        if (bit_cnt < 4'd7)
                        begin
                            shreg   <= shreg << 1;
                            bit_cmd <= '{op: eeprom_pkg::BIT_WRITE, wbit: shreg[6]};
                        end
                        else if (bit_cnt == 4'd7)
                            bit_cmd <= '{op: eeprom_pkg::BIT_READ, wbit: 1'b1};  // slave ack
                        else if (bit_rx)
                        begin
                            nack_q  <= 1'b1;   // abort
                            bit_cmd <= '{op: eeprom_pkg::BIT_STOP, wbit: 1'b1};
                            state   <= ST_STOP;
                        end
                        else
                        begin
                            bit_cnt <= '0;
                            case (state)
                                ST_CTRL_WR:
                                begin
                                    shreg   <= addr_q[7:0];
                                    bit_cmd <= '{op: eeprom_pkg::BIT_WRITE, wbit: addr_q[7]};
                                    state   <= ST_ADDR;
                                end
                                ST_ADDR:
                                    if (rd_q)
                                    begin
                                        ctrl.fields.rw <= 1'b1;
                                        bit_cmd <= '{op: eeprom_pkg::BIT_START, wbit: 1'b1};
                                        state   <= ST_RESTART;
                                    end
                                    else
                                    begin
                                        shreg   <= wdata_q;
                                        bit_cmd <= '{op: eeprom_pkg::BIT_WRITE, wbit: wdata_q[7]};
                                        state   <= ST_DATA_WR;
                                    end
                                ST_DATA_WR:
                                begin
                                    bit_cmd <= '{op: eeprom_pkg::BIT_STOP, wbit: 1'b1};
                                    state   <= ST_STOP;
                                end
                                default:
                                begin
                                    bit_cmd <= '{op: eeprom_pkg::BIT_READ, wbit: 1'b1};
                                    state   <= ST_DATA_RD;
                                end
                            endcase
                        end
                    end
                ST_DATA_RD:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        bit_go  <= 1'b1;
                        if (bit_cnt < 4'd8)
                            shreg <= {shreg[6:0], bit_rx};   // msb first
                        if (bit_cnt < 4'd7)
                            bit_cmd <= '{op: eeprom_pkg::BIT_READ, wbit: 1'b1};
                        else if (bit_cnt == 4'd7)
                            bit_cmd <= '{op: eeprom_pkg::BIT_WRITE, wbit: 1'b1};  // master nack
                        else
                        begin
                            bit_cmd <= '{op: eeprom_pkg::BIT_STOP, wbit: 1'b1};
                            state   <= ST_STOP;
                        end
                    end
                ST_STOP:
                    if (bit_done)
                        state <= ST_DONE;
                ST_DONE:
                begin
                    done       <= 1'b1;
                    busy       <= 1'b0;
                    rsp.rdata  <= (rd_q && !nack_q) ? shreg : 8'h00;
                    rsp.nack   <= nack_q;
                    state      <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    a_done_pulse: assert property (
        @(posedge CLK) disable iff (RESET)
        done |=> !done
    );

    a_go_busy: assert property (
        @(posedge CLK) disable iff (RESET)
        bit_go |-> busy
    );

endmodule

/* eeprom_cfg_regs.sv */
`timescale 1ns/10ps

module eeprom_cfg_regs
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cfg_wr,
    input  logic                     cfg_sel,
    input  logic [7:0]               cfg_wdata,
    output eeprom_pkg::eeprom_cfg_t  cfg
);

    logic [eeprom_pkg::SCL_DIV_W-1:0] scl_div;
    logic [3:0]                       dev_code;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_div  <= eeprom_pkg::SCL_DIV_RESET;
            dev_code <= eeprom_pkg::DEV_CODE_RESET;
        end
        else if (cfg_wr)
        begin
            case (cfg_sel)
                eeprom_pkg::CFG_SEL_DIV:
                begin
                    // zero would give a one clock quarter
                    if (cfg_wdata == 8'd0)
                        scl_div <= 8'd1;
                    else
                        scl_div <= cfg_wdata;
                end
                eeprom_pkg::CFG_SEL_DEV:
                begin
                    dev_code <= cfg_wdata[3:0];   // upper nibble ignored
                end
                default:
                begin
                    scl_div <= scl_div;
                end
            endcase
        end
    end

    assign cfg.scl_div  = scl_div;
    assign cfg.dev_code = dev_code;

    // bit engine relies on a quarter of at least two clocks
    a_div_nonzero: assert property (
        @(posedge CLK) disable iff (RESET)
        cfg.scl_div != '0
    );

endmodule

/* eeprom_ctrl_top.sv */
`timescale 1ns/10ps

module eeprom_ctrl_top
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       req_wr,
    input  logic                       req_rd,
    input  eeprom_pkg::eeprom_req_t    req,
    input  logic                       cfg_wr,
    input  logic                       cfg_sel,
    input  logic [7:0]                 cfg_wdata,
    output logic                       busy,
    output logic                       done,
    output eeprom_pkg::eeprom_rsp_t    rsp,
    output logic                       scl,
    output logic                       sda_pull_low,
    input  logic                       sda_in
);

    eeprom_pkg::eeprom_cfg_t  cfg;
    eeprom_pkg::bit_cmd_t     bit_cmd;
    logic                     bit_go;
    logic                     bit_done;
    logic                     bit_rx;

    eeprom_cfg_regs cfg_regs_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg_wr    (cfg_wr),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    eeprom_byte_sequencer sequencer_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .req_wr   (req_wr),
        .req_rd   (req_rd),
        .req      (req),
        .dev_code (cfg.dev_code),
        .busy     (busy),
        .done     (done),
        .rsp      (rsp),
        .bit_go   (bit_go),
        .bit_cmd  (bit_cmd),
        .bit_done (bit_done),
        .bit_rx   (bit_rx)
    );

    i2c_bit_engine bit_engine_inst (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl_div      (cfg.scl_div),
        .bit_go       (bit_go),
        .bit_cmd      (bit_cmd),
        .bit_done     (bit_done),
        .bit_rx       (bit_rx),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    // byte address of the 2 KB part, 8 blocks of 256
    localparam int ADDR_W = 11;

    localparam int SCL_DIV_W = 8;

    localparam logic [3:0] DEV_CODE_RESET = 4'b1010;

    // one SCL quarter lasts divider+1 clocks
    localparam logic [SCL_DIV_W-1:0] SCL_DIV_RESET = 8'd4;

    localparam logic CFG_SEL_DIV = 1'b0;
    localparam logic CFG_SEL_DEV = 1'b1;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;   // slave did not answer
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    wbit;
    } bit_cmd_t;

    typedef struct packed {
        logic [SCL_DIV_W-1:0] scl_div;
        logic [3:0]           dev_code;
    } eeprom_cfg_t;

    // control byte sent after every start
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block;  // address bits 10..8
            logic       rw;     // 1 for read
        } fields;
    } ctrl_byte_u;

endpackage

/* i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine
(
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic [eeprom_pkg::SCL_DIV_W-1:0]  scl_div,
    input  logic                              bit_go,
    input  eeprom_pkg::bit_cmd_t              bit_cmd,
    output logic                              bit_done,
    output logic                              bit_rx,
    output logic                              scl,
    output logic                              sda_pull_low,
    input  logic                              sda_in
);

    logic                              running;
    logic [1:0]                        phase;     // quarter 1..4 as 0..3
    logic [eeprom_pkg::SCL_DIV_W-1:0]  qcnt;
    logic [eeprom_pkg::SCL_DIV_W-1:0]  div_q;     // divider of the running command
    eeprom_pkg::bit_cmd_t              cmd_q;
    logic                              q_end;
    logic                              last_cycle;

    // scl level for a quarter
    function automatic logic scl_level(eeprom_pkg::bit_op_e op, logic [1:0] ph);
        if (op == eeprom_pkg::BIT_START)
            scl_level = (ph == 2'd1) || (ph == 2'd2);
        else
            scl_level = ph[1];
    endfunction

    // sda drive for a quarter, 1 pulls the line low
    function automatic logic sda_level(eeprom_pkg::bit_cmd_t cmd, logic [1:0] ph);
        case (cmd.op)
            eeprom_pkg::BIT_START: sda_level = ph[1];          // falls after quarter 2
            eeprom_pkg::BIT_STOP:  sda_level = (ph != 2'd3);   // released in quarter 4
            eeprom_pkg::BIT_WRITE: sda_level = ~cmd.wbit;
            default:               sda_level = 1'b0;
        endcase
    endfunction

    assign q_end      = (qcnt == div_q);
    assign last_cycle = running && (phase == 2'd3) && q_end;

    // one cycle early so the next bit_go lands on the last cycle of quarter 4
    assign bit_done = running && (phase == 2'd3) && (qcnt == div_q - 8'd1);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running      <= 1'b0;
            phase        <= 2'd0;
            qcnt         <= '0;
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
        end
        else if (bit_go)
        begin
            running <= 1'b1;
            phase   <= 2'd0;
            qcnt    <= '0;
            scl     <= scl_level(bit_cmd.op, 2'd0);
        end
        else if (running)
        begin
            if (q_end)
            begin
                qcnt <= '0;
                if (phase == 2'd3)
                begin
                    running <= 1'b0;   // lines hold their last state
                end
                else
                begin
                    phase        <= phase + 2'd1;
                    scl          <= scl_level(cmd_q.op, phase + 2'd1);
                    sda_pull_low <= sda_level(cmd_q, phase + 2'd1);
                end
            end
            else
            begin
                qcnt <= qcnt + 8'd1;
                // sda moves one clock after scl has gone low
                if (phase == 2'd0 && qcnt == '0)
                    sda_pull_low <= sda_level(cmd_q, 2'd0);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bit_go)
        begin
            cmd_q <= bit_cmd;
            div_q <= scl_div;   // new divider only at a command boundary
        end
        if (running && phase == 2'd2 && q_end)
            bit_rx <= sda_in;   // mid-high sample
    end

    a_single_cmd: assert property (
        @(posedge CLK) disable iff (RESET)
        bit_go |-> (!running || last_cycle)
    );

    // data bits keep sda stable while scl is high
    a_sda_scl_low: assert property (
        @(posedge CLK) disable iff (RESET)
        (running && (cmd_q.op == eeprom_pkg::BIT_WRITE || cmd_q.op == eeprom_pkg::BIT_READ)
            && $changed(sda_pull_low)) |-> !scl
    );

endmodule

/* tb_eeprom_ctrl.sv */
`timescale 1ns/10ps

module tb_eeprom_ctrl;

    localparam int ROWS    = 26;
    localparam int PAIRS   = 16;
    localparam int MAX_DIV = 9;
    localparam int LIMIT   = (ROWS + 32) * 39 * 4 * (MAX_DIV + 1) + 1000;

    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_DIV = 2'd2;
    localparam logic [1:0] OP_DEV = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [10:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_rdata;
        logic        exp_nack;
    } row_t;

    logic                     CLK;
    logic                     RESET;
    logic                     req_wr;
    logic                     req_rd;
    eeprom_pkg::eeprom_req_t  req;
    logic                     cfg_wr;
    logic                     cfg_sel;
    logic [7:0]               cfg_wdata;
    logic                     busy;
    logic                     done;
    eeprom_pkg::eeprom_rsp_t  rsp;
    logic                     scl;
    logic                     sda_pull_low;
    logic                     model_pull_low;
    logic                     sda;

    row_t        rows [ROWS];
    logic [7:0]  shadow [0:2047];
    logic [31:0] rnd = 32'hdb42;
    int          cur_div = 4;
    int          cycle_cnt = 0;
    int          done_cnt = 0;
    int          hi_cnt = 0;
    logic        measure_en = 1'b0;
    logic        hi_valid = 1'b0;
    logic        scl_seen = 1'b1;

    assign sda = ~(sda_pull_low | model_pull_low);   // wired-AND with pull-up

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK          (CLK),
        .RESET        (RESET),
        .req_wr       (req_wr),
        .req_rd       (req_rd),
        .req          (req),
        .cfg_wr       (cfg_wr),
        .cfg_sel      (cfg_sel),
        .cfg_wdata    (cfg_wdata),
        .busy         (busy),
        .done         (done),
        .rsp          (rsp),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda)
    );

    tb_eeprom_model model_inst (
        .scl          (scl),
        .sda          (sda),
        .sda_pull_low (model_pull_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // strobe to done clocks from the command count of each transaction
    function automatic int txn_clocks(input logic wr, input logic nack, input int div);
        int cmds;
        if (nack)
            cmds = 11;
        else if (wr)
            cmds = 29;
        else
            cmds = 39;
        txn_clocks = 2 + cmds * 4 * (div + 1);
    endfunction

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
        begin
            $display("tests failed");
            $fatal(1, "timeout, run did not finish within %0d clock cycles", LIMIT);
        end
    end

    // scl high time counted on falling clock edges
    always @(negedge CLK)
    begin
        if (done)
        begin
            done_cnt++;
            hi_valid = 1'b0;   // scl stays high while idle
        end
        if (scl && !scl_seen)
        begin
            hi_cnt   = 1;
            hi_valid = measure_en;
        end
        else if (scl)
            hi_cnt++;
        else if (scl_seen && hi_valid && measure_en)
            check("scl high clocks", 32'(hi_cnt), 32'(2 * (cur_div + 1)));
        scl_seen = scl;
    end

    task automatic run_txn(input logic wr, input logic [10:0] addr, input logic [7:0] data,
                           input logic stray, output logic [7:0] rdata, output logic nack,
                           output int cycles);
        @(negedge CLK);
        req    = '{write: wr, addr: addr, wdata: data};
        req_wr = wr;
        req_rd = ~wr;
        @(negedge CLK);
        req_wr = 1'b0;
        req_rd = 1'b0;
        cycles = 1;
        while (!done)
        begin
            @(negedge CLK);
            cycles++;
            if (stray && cycles == 20)
            begin
                req    = '{write: 1'b1, addr: 11'h6c3, wdata: 8'hbd};
                req_wr = 1'b1;   // must be ignored while busy
            end
            else
                req_wr = 1'b0;
        end
        rdata = rsp.rdata;
        nack  = rsp.nack;
    endtask

    task automatic apply_row(input row_t r);
        logic [7:0] rdata;
        logic       nack;
        int         cycles;
        case (r.op)
            OP_DIV, OP_DEV:
            begin
                @(negedge CLK);
                cfg_wr    = 1'b1;
                cfg_sel   = (r.op == OP_DEV) ? eeprom_pkg::CFG_SEL_DEV : eeprom_pkg::CFG_SEL_DIV;
                cfg_wdata = r.data;
                @(negedge CLK);
                cfg_wr = 1'b0;
                if (r.op == OP_DIV)
                    cur_div = (r.data == 8'd0) ? 1 : int'(r.data);
            end
            default:
            begin
                measure_en = (cur_div == MAX_DIV);
                run_txn(r.op == OP_WR, r.addr, r.data, 1'b0, rdata, nack, cycles);
                measure_en = 1'b0;
                check("rsp.nack", 32'(nack), 32'(r.exp_nack));
                check("rsp.rdata", 32'(rdata), 32'(r.exp_rdata));
                check("strobe to done clocks", 32'(cycles),
                      32'(txn_clocks(r.op == OP_WR, r.exp_nack, cur_div)));
                if (r.op == OP_WR && !r.exp_nack)
                    shadow[r.addr] = r.data;
            end
        endcase
    endtask

    initial
    begin
        logic [7:0]  rdata;
        logic        nack;
        int          cycles;
        int          dones_before;
        logic [10:0] a;
        logic [7:0]  d;
        RESET     = 1'b1;
        req_wr    = 1'b0;
        req_rd    = 1'b0;
        req       = '0;
        cfg_wr    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_wdata = 8'h00;

        rows[0]  = '{OP_WR,  11'h000, 8'ha5, 8'h00, 1'b0};
        rows[1]  = '{OP_WR,  11'h7ff, 8'h3c, 8'h00, 1'b0};
        rows[2]  = '{OP_WR,  11'h100, 8'h11, 8'h00, 1'b0};
        rows[3]  = '{OP_WR,  11'h2ff, 8'h22, 8'h00, 1'b0};
        rows[4]  = '{OP_WR,  11'h345, 8'h33, 8'h00, 1'b0};
        rows[5]  = '{OP_WR,  11'h480, 8'h44, 8'h00, 1'b0};
        rows[6]  = '{OP_WR,  11'h5aa, 8'h55, 8'h00, 1'b0};
        rows[7]  = '{OP_WR,  11'h6c3, 8'h66, 8'h00, 1'b0};
        rows[8]  = '{OP_RD,  11'h000, 8'h00, 8'ha5, 1'b0};
        rows[9]  = '{OP_RD,  11'h7ff, 8'h00, 8'h3c, 1'b0};
        rows[10] = '{OP_RD,  11'h100, 8'h00, 8'h11, 1'b0};
        rows[11] = '{OP_RD,  11'h2ff, 8'h00, 8'h22, 1'b0};
        rows[12] = '{OP_RD,  11'h345, 8'h00, 8'h33, 1'b0};
        rows[13] = '{OP_RD,  11'h480, 8'h00, 8'h44, 1'b0};
        rows[14] = '{OP_RD,  11'h5aa, 8'h00, 8'h55, 1'b0};
        rows[15] = '{OP_RD,  11'h6c3, 8'h00, 8'h66, 1'b0};
        rows[16] = '{OP_WR,  11'h345, 8'h99, 8'h00, 1'b0};   // overwrite
        rows[17] = '{OP_RD,  11'h345, 8'h00, 8'h99, 1'b0};
        rows[18] = '{OP_DIV, 11'h000, 8'd9,  8'h00, 1'b0};
        rows[19] = '{OP_WR,  11'h123, 8'h77, 8'h00, 1'b0};
        rows[20] = '{OP_RD,  11'h123, 8'h00, 8'h77, 1'b0};
        rows[21] = '{OP_DEV, 11'h000, 8'h06, 8'h00, 1'b0};
        rows[22] = '{OP_WR,  11'h100, 8'hee, 8'h00, 1'b1};   // wrong device code
        rows[23] = '{OP_DEV, 11'h000, 8'h0a, 8'h00, 1'b0};
        rows[24] = '{OP_RD,  11'h100, 8'h00, 8'h11, 1'b0};
        rows[25] = '{OP_DIV, 11'h000, 8'd4,  8'h00, 1'b0};

        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check("scl", 32'(scl), 32'd1);
        check("sda_pull_low", 32'(sda_pull_low), 32'd0);
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);

        for (int i = 0; i < ROWS; i++)
            apply_row(rows[i]);

        // second strobe while busy
        dones_before = done_cnt;
        run_txn(1'b1, 11'h0ab, 8'h5e, 1'b1, rdata, nack, cycles);
        check("rsp.nack", 32'(nack), 32'd0);
        shadow[11'h0ab] = 8'h5e;
        repeat (200) @(negedge CLK);
        check("done count", 32'(done_cnt - dones_before), 32'd1);
        check("busy", 32'(busy), 32'd0);
        run_txn(1'b0, 11'h6c3, 8'h00, 1'b0, rdata, nack, cycles);
        check("rsp.rdata", 32'(rdata), 32'(shadow[11'h6c3]));
        run_txn(1'b0, 11'h0ab, 8'h00, 1'b0, rdata, nack, cycles);
        check("rsp.rdata", 32'(rdata), 32'(shadow[11'h0ab]));

        for (int i = 0; i < PAIRS; i++)
        begin
            rnd = lcg_next(rnd);
            a   = rnd[26:16];
            rnd = lcg_next(rnd);
            d   = rnd[23:16];
            run_txn(1'b1, a, d, 1'b0, rdata, nack, cycles);
            check("rsp.nack", 32'(nack), 32'd0);
            shadow[a] = d;
            run_txn(1'b0, a, 8'h00, 1'b0, rdata, nack, cycles);
            check("rsp.nack", 32'(nack), 32'd0);
            check("rsp.rdata", 32'(rdata), 32'(shadow[a]));
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* tb_eeprom_model.sv */
`timescale 1ns/10ps

module tb_eeprom_model
(
    input  logic scl,
    input  logic sda,
    output logic sda_pull_low
);

    localparam logic [3:0] OWN_CODE = 4'b1010;

    typedef enum logic [2:0] {
        M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_TX, M_IGNORE
    } mstate_e;

    logic [7:0]             mem [0:2047];
    mstate_e                mstate = M_IDLE;
    logic [3:0]             bitn = 4'd0;     // 0..7 data, 8 ack slot
    logic [7:0]             shift = 8'h00;
    logic [10:0]            addr = 11'd0;
    logic                   read_mode = 1'b0;
    logic                   skip_fall = 1'b0;  // scl fall that closes a start
    logic                   scl_q = 1'b1;
    logic                   sda_q = 1'b1;
    eeprom_pkg::ctrl_byte_u ctrl;

    initial
    begin
        sda_pull_low = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 7 + (i >> 8));   // pattern over the whole address
    end

    always @(scl or sda)
    begin
        if (scl !== scl_q)
        begin
            if (scl === 1'b1)
            begin
                if ((mstate == M_CTRL || mstate == M_ADDR || mstate == M_WDATA) && bitn < 4'd8)
                    shift = {shift[6:0], sda};
            end
            else if (skip_fall)
                skip_fall = 1'b0;
            else if (mstate != M_IDLE && mstate != M_IGNORE)
            begin
                if (bitn < 4'd7)
                begin
                    bitn = bitn + 4'd1;
                    if (mstate == M_TX)
                    begin
                        shift        = shift << 1;
                        sda_pull_low = ~shift[7];
                    end
                end
                else if (bitn == 4'd7)
                begin
                    bitn         = 4'd8;
                    sda_pull_low = 1'b0;   // master acks in TX
                    case (mstate)
                        M_CTRL:
                        begin
                            ctrl.raw = shift;
                            if (ctrl.fields.dev_code == OWN_CODE)
                            begin
                                read_mode    = ctrl.fields.rw;
                                addr[10:8]   = ctrl.fields.block;
                                sda_pull_low = 1'b1;
                            end
                            else
                                mstate = M_IGNORE;   // not our code, no ack
                        end
                        M_ADDR:
                        begin
                            addr[7:0]    = shift;
                            sda_pull_low = 1'b1;
                        end
                        M_WDATA:
                        begin
                            mem[addr]    = shift;
                            sda_pull_low = 1'b1;
                        end
                        default:
                            sda_pull_low = 1'b0;
                    endcase
                end
                else
                begin
                    bitn         = 4'd0;
                    sda_pull_low = 1'b0;
                    case (mstate)
                        M_CTRL:
                            if (read_mode)
                            begin
                                mstate       = M_TX;
                                shift        = mem[addr];
                                sda_pull_low = ~shift[7];
                            end
                            else
                                mstate = M_ADDR;
                        M_ADDR:  mstate = M_WDATA;
                        M_WDATA: mstate = M_IGNORE;   // single byte only
                        default: mstate = M_IDLE;
                    endcase
                end
            end
        end
        else if (sda !== sda_q && scl === 1'b1)
        begin
            sda_pull_low = 1'b0;
            if (sda === 1'b0)
            begin
                mstate    = M_CTRL;   // start or repeated start
                bitn      = 4'd0;
                shift     = 8'h00;
                skip_fall = 1'b1;
            end
            else
            begin
                mstate    = M_IDLE;   // stop
                skip_fall = 1'b0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule
